//--- hdl/arch_map_table.sv
// architectural map table: committed register mapping, written at retirement
module arch_map_table (
  input  logic                                                     clock,
  input  logic                                                     reset,
  input  logic [rename_pkg::lanes-1:0]                             retire_valid,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]        retire_ar,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]        retire_pr,
  output logic [rename_pkg::arch_count-1:0][rename_pkg::prw-1:0]   arch_map
);
  import rename_pkg::*;

  logic [arch_count-1:0][prw-1:0] arch_next;

  // retire lane 1 before lane 0,
  // the younger write to the same register lands last
  always_comb begin
    arch_next = arch_map;
    for (int lane = lanes - 1; lane >= 0; lane--) begin
      if (retire_valid[lane]) begin
        arch_next[retire_ar[lane]] = retire_pr[lane];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity: register n lives in physical register n
      for (int r = 0; r < arch_count; r++) begin
        arch_map[r] <= prw'(r);
      end
    end else begin
      arch_map <= arch_next;
    end
  end

endmodule

//--- hdl/free_list.sv
// free list: bitmap of free physical tags, lowest-first allocation and rebuild
module free_list (
  input  logic                                                     clock,
  input  logic                                                     reset,
  input  logic [rename_pkg::lanes-1:0]                             alloc_en,
  input  logic [rename_pkg::lanes-1:0]                             release_en,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]        release_tag,
  input  logic                                                     recover,
  input  logic [rename_pkg::arch_count-1:0][rename_pkg::prw-1:0]   arch_map,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]        alloc_tag,
  output logic [rename_pkg::fcw-1:0]                               free_count
);
  import rename_pkg::*;

  logic [phys_regs-1:0] free_q;
  logic [phys_regs-1:0] free_next;
  logic [phys_regs-1:0] arch_held;
  logic [prw-1:0]       first_tag;
  logic [prw-1:0]       second_tag;
  logic                 have_first;
  logic                 have_second;

  // two lowest free tags, scanning up from tag 0
  always_comb begin
    first_tag   = '0;
    second_tag  = '0;
    have_first  = 1'b0;
    have_second = 1'b0;
    for (int t = 0; t < phys_regs; t++) begin
      if (free_q[t] && !have_first) begin
        first_tag  = prw'(t);
        have_first = 1'b1;
      end else if (free_q[t] && !have_second) begin
        second_tag  = prw'(t);
        have_second = 1'b1;
      end
    end
  end

  // lane 1 always gets the lowest, lane 0 only takes the lowest when it allocates alone
  assign alloc_tag[1] = first_tag;
  assign alloc_tag[0] = (alloc_en == 2'b01) ? first_tag : second_tag;

  always_comb begin
    free_count = '0;
    for (int t = 0; t < phys_regs; t++) begin
      free_count = free_count + fcw'(free_q[t]);
    end
  end

  // tags still named by the committed map are the only ones in use after recovery
  always_comb begin
    arch_held = '0;
    for (int r = 0; r < arch_count; r++) begin
      arch_held[arch_map[r]] = 1'b1;
    end
  end

  always_comb begin
    free_next = free_q;
    if (alloc_en[1] && have_first) begin
      free_next[alloc_tag[1]] = 1'b0;
    end
    if (alloc_en[0] && (alloc_en[1] ? have_second : have_first)) begin
      free_next[alloc_tag[0]] = 1'b0;
    end
    // a retired told is never one of the tags being handed out
    for (int lane = 0; lane < lanes; lane++) begin
      if (release_en[lane]) begin
        free_next[release_tag[lane]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int t = 0; t < phys_regs; t++) begin
        free_q[t] <= (t >= arch_count);
      end
    end else if (recover) begin
      free_q <= ~arch_held;
    end else begin
      free_q <= free_next;
    end
  end

endmodule

//--- hdl/map_table.sv
// speculative map table: source lookup, CDB wakeup, in-group folding and told
module map_table (
  input  logic                                                     clock,
  input  logic                                                     reset,
  input  logic [rename_pkg::arch_count-1:0][rename_pkg::prw-1:0]   arch_map,
  input  logic                                                     recover,
  input  logic [rename_pkg::lanes-1:0]                             cdb_valid,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]        cdb_tag,
  input  logic [rename_pkg::lanes-1:0]                             alloc_en,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]        dest_ar,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]        new_tag,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]        src1_ar,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]        src2_ar,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]        src1_tag,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]        src2_tag,
  output logic [rename_pkg::lanes-1:0]                             src1_ready,
  output logic [rename_pkg::lanes-1:0]                             src2_ready,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]        told
);
  import rename_pkg::*;

  logic [arch_count-1:0][prw-1:0] map_q;
  logic [arch_count-1:0]          rdy_q;

  // stage lanes is the current state after wakeup,
  // stage n is the state after lane n has been folded in, stage 0 is next state
  logic [lanes:0][arch_count-1:0][prw-1:0] map_s;
  logic [lanes:0][arch_count-1:0]          rdy_s;

  // a valid broadcast of this tag this cycle, tag 0 never wakes anything
  function automatic logic cdb_hit(input logic [prw-1:0]              tag,
                                   input logic [lanes-1:0]            v,
                                   input logic [lanes-1:0][prw-1:0]   t);
    logic hit;
    hit = 1'b0;
    if (tag != '0) begin
      for (int c = 0; c < lanes; c++) begin
        if (v[c] && (t[c] == tag)) begin
          hit = 1'b1;
        end
      end
    end
    return hit;
  endfunction

  always_comb begin
    map_s[lanes] = map_q;
    rdy_s[lanes] = rdy_q;
    for (int r = 0; r < arch_count; r++) begin
      if (cdb_hit(map_q[r], cdb_valid, cdb_tag)) begin
        rdy_s[lanes][r] = 1'b1;
      end
    end

    // oldest lane first so the youngest writer of a register wins
    for (int lane = lanes - 1; lane >= 0; lane--) begin
      map_s[lane] = map_s[lane+1];
      rdy_s[lane] = rdy_s[lane+1];
      if (alloc_en[lane]) begin
        map_s[lane][dest_ar[lane]] = new_tag[lane];
        // r0 never waits on anything
        rdy_s[lane][dest_ar[lane]] = (dest_ar[lane] == '0);
      end
    end
  end

  // each lane sees the group state left behind by the older lanes
  always_comb begin
    for (int lane = 0; lane < lanes; lane++) begin
      src1_tag[lane]   = map_s[lane+1][src1_ar[lane]];
      src2_tag[lane]   = map_s[lane+1][src2_ar[lane]];
      src1_ready[lane] = rdy_s[lane+1][src1_ar[lane]];
      src2_ready[lane] = rdy_s[lane+1][src2_ar[lane]];
    end
  end

  // old mapping, patched by any older lane of the group writing the same register
  always_comb begin
    for (int lane = 0; lane < lanes; lane++) begin
      told[lane] = map_q[dest_ar[lane]];
      for (int older = lane + 1; older < lanes; older++) begin
        if (alloc_en[older] && (dest_ar[older] == dest_ar[lane])) begin
          told[lane] = new_tag[older];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < arch_count; r++) begin
        map_q[r] <= prw'(r);
      end
      rdy_q <= '1;
    end else if (recover) begin
      // committed values are all produced, so everything is ready
      map_q <= arch_map;
      rdy_q <= '1;
    end else begin
      map_q <= map_s[0];
      rdy_q <= rdy_s[0];
    end
  end

endmodule

//--- hdl/rename_core.sv
// rename core: free list, map tables and reorder buffer with group stall control
module rename_core (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic [rename_pkg::lanes-1:0]                        rename_valid,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]   dest_ar,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]   src1_ar,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]   src2_ar,
  input  logic [rename_pkg::lanes-1:0]                        cdb_valid,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   cdb_tag,
  input  logic                                                recover,
  output logic                                                stall,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   dest_pr,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   told,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   src1_tag,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   src2_tag,
  output logic [rename_pkg::lanes-1:0]                        src1_ready,
  output logic [rename_pkg::lanes-1:0]                        src2_ready,
  output logic [rename_pkg::lanes-1:0]                        retire_valid,
  output logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]   retire_ar,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   retire_pr
);
  import rename_pkg::*;

  logic [lanes-1:0]                  alloc_en;
  logic [fcw-1:0]                    free_count;
  logic [rmw-1:0]                    room;
  logic [lanes-1:0][prw-1:0]         offer_tag;
  logic [lanes-1:0][prw-1:0]         retire_told;
  logic [arch_count-1:0][prw-1:0]    arch_map;
  logic [1:0]                        n_valid;

  // a group goes in whole or not at all
  assign n_valid  = 2'(rename_valid[1]) + 2'(rename_valid[0]);
  assign stall    = (free_count < fcw'(n_valid)) || (room < rmw'(n_valid));
  assign alloc_en = rename_valid & {lanes{!stall && !recover}};

  // lane 0 is offered the lowest free tag whenever lane 1 is not renaming, stalled or not
  assign dest_pr[1] = offer_tag[1];
  assign dest_pr[0] = rename_valid[1] ? offer_tag[0] : offer_tag[1];

  free_list free_list_i (
    .clock       (clock),
    .reset       (reset),
    .alloc_en    (alloc_en),
    .release_en  (retire_valid),
    .release_tag (retire_told),
    .recover     (recover),
    .arch_map    (arch_map),
    .alloc_tag   (offer_tag),
    .free_count  (free_count)
  );

  map_table map_table_i (
    .clock      (clock),
    .reset      (reset),
    .arch_map   (arch_map),
    .recover    (recover),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .alloc_en   (alloc_en),
    .dest_ar    (dest_ar),
    .new_tag    (dest_pr),
    .src1_ar    (src1_ar),
    .src2_ar    (src2_ar),
    .src1_tag   (src1_tag),
    .src2_tag   (src2_tag),
    .src1_ready (src1_ready),
    .src2_ready (src2_ready),
    .told       (told)
  );

  reorder_buffer reorder_buffer_i (
    .clock        (clock),
    .reset        (reset),
    .recover      (recover),
    .alloc_en     (alloc_en),
    .dest_ar      (dest_ar),
    .new_tag      (dest_pr),
    .told         (told),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .room         (room),
    .retire_valid (retire_valid),
    .retire_ar    (retire_ar),
    .retire_pr    (retire_pr),
    .retire_told  (retire_told)
  );

  arch_map_table arch_map_table_i (
    .clock        (clock),
    .reset        (reset),
    .retire_valid (retire_valid),
    .retire_ar    (retire_ar),
    .retire_pr    (retire_pr),
    .arch_map     (arch_map)
  );

endmodule

//--- hdl/rename_pkg.sv
// rename package: sizes, tag and index widths and reorder-buffer slot states
package rename_pkg;

  // architectural register file size
  localparam int arch_count = 32;

  // physical register file size, twice the architectural one
  localparam int phys_regs = 64;

  // rename and retire width
  // lane 1 carries the older instruction, lane 0 the younger
  localparam int lanes = 2;

  // reorder buffer entries
  localparam int rob_depth = 16;

  // architectural index width
  localparam int arw = $clog2(arch_count);

  // physical tag width
  localparam int prw = $clog2(phys_regs);

  // reorder buffer pointer width
  localparam int rbw = $clog2(rob_depth);

  // free tag count, must hold phys_regs itself
  localparam int fcw = $clog2(phys_regs + 1);

  // reorder buffer room, must hold rob_depth itself
  localparam int rmw = $clog2(rob_depth + 1);

  // per-slot state of the reorder buffer
  //   slot_empty   nothing held
  //   slot_waiting renamed, result not yet broadcast
  //   slot_done    tag seen on the CDB, may retire
  typedef enum logic [1:0] {
    slot_empty,
    slot_waiting,
    slot_done
  } entry_state_t;

endpackage

//--- hdl/reorder_buffer.sv
// reorder buffer: in-order store of renamed instructions, CDB completion, two-wide retire
module reorder_buffer (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic                                                recover,
  input  logic [rename_pkg::lanes-1:0]                        alloc_en,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]   dest_ar,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   new_tag,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   told,
  input  logic [rename_pkg::lanes-1:0]                        cdb_valid,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   cdb_tag,
  output logic [rename_pkg::rmw-1:0]                          room,
  output logic [rename_pkg::lanes-1:0]                        retire_valid,
  output logic [rename_pkg::lanes-1:0][rename_pkg::arw-1:0]   retire_ar,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   retire_pr,
  output logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0]   retire_told
);
  import rename_pkg::*;

  entry_state_t   state_q [rob_depth];
  logic [arw-1:0] dest_q  [rob_depth];
  logic [prw-1:0] new_q   [rob_depth];
  logic [prw-1:0] told_q  [rob_depth];

  logic [rbw-1:0] head_q;
  logic [rbw-1:0] tail_q;
  logic [rmw-1:0] count_q;

  logic [lanes-1:0][rbw-1:0] ret_idx;
  logic [lanes-1:0][rbw-1:0] app_idx;
  logic [rmw-1:0]            n_alloc;
  logic [rmw-1:0]            n_retire;

  assign room = rmw'(rob_depth) - count_q;

  // head is the oldest, lane 1; lane 0 goes into the slot behind lane 1 only if lane 1 appends
  assign ret_idx[1] = head_q;
  assign ret_idx[0] = head_q + rbw'(1);
  assign app_idx[1] = tail_q;
  assign app_idx[0] = tail_q + rbw'(alloc_en[1]);

  // slots past the tail are always empty, so the state alone tells occupancy
  always_comb begin
    retire_valid[1] = !recover && (state_q[ret_idx[1]] == slot_done);
    retire_valid[0] = retire_valid[1] && (state_q[ret_idx[0]] == slot_done);
    for (int lane = 0; lane < lanes; lane++) begin
      retire_ar[lane]   = dest_q[ret_idx[lane]];
      retire_pr[lane]   = new_q[ret_idx[lane]];
      retire_told[lane] = told_q[ret_idx[lane]];
    end
  end

  always_comb begin
    n_alloc  = '0;
    n_retire = '0;
    for (int lane = 0; lane < lanes; lane++) begin
      n_alloc  = n_alloc + rmw'(alloc_en[lane]);
      n_retire = n_retire + rmw'(retire_valid[lane]);
    end
  end

  // complete, retire and append never touch the same slot in one cycle
  always_ff @(posedge clock) begin
    if (reset || recover) begin
      for (int s = 0; s < rob_depth; s++) begin
        state_q[s] <= slot_empty;
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      for (int s = 0; s < rob_depth; s++) begin
        for (int c = 0; c < lanes; c++) begin
          if (state_q[s] == slot_waiting && cdb_valid[c] && new_q[s] == cdb_tag[c]) begin
            state_q[s] <= slot_done;
          end
        end
      end
      for (int lane = 0; lane < lanes; lane++) begin
        if (retire_valid[lane]) begin
          state_q[ret_idx[lane]] <= slot_empty;
        end
        if (alloc_en[lane]) begin
          state_q[app_idx[lane]] <= slot_waiting;
        end
      end
      head_q  <= head_q + rbw'(n_retire);
      tail_q  <= tail_q + rbw'(n_alloc);
      count_q <= count_q + n_alloc - n_retire;
    end
  end

  always_ff @(posedge clock) begin
    for (int lane = 0; lane < lanes; lane++) begin
      if (alloc_en[lane]) begin
        dest_q[app_idx[lane]] <= dest_ar[lane];
        new_q[app_idx[lane]]  <= new_tag[lane];
        told_q[app_idx[lane]] <= told[lane];
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the rename core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module rename_tb \
  -o rename_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rename_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log"; then
  exit 0
else
  exit 1
fi

//--- verification/rename_tb.sv
// rename core testbench: replays per-cycle vectors from a file and checks outputs
module rename_tb;
  import rename_pkg::*;

  localparam string test_file   = "verification/rename_tests.txt";
  localparam int    field_count = 29;
  localparam int    max_lines   = 64;
  localparam int    half_period = 10;

  logic                      clock;
  logic                      reset;
  logic [lanes-1:0]          rename_valid;
  logic [lanes-1:0][arw-1:0] dest_ar;
  logic [lanes-1:0][arw-1:0] src1_ar;
  logic [lanes-1:0][arw-1:0] src2_ar;
  logic [lanes-1:0]          cdb_valid;
  logic [lanes-1:0][prw-1:0] cdb_tag;
  logic                      recover;
  logic                      stall;
  logic [lanes-1:0][prw-1:0] dest_pr;
  logic [lanes-1:0][prw-1:0] told;
  logic [lanes-1:0][prw-1:0] src1_tag;
  logic [lanes-1:0][prw-1:0] src2_tag;
  logic [lanes-1:0]          src1_ready;
  logic [lanes-1:0]          src2_ready;
  logic [lanes-1:0]          retire_valid;
  logic [lanes-1:0][arw-1:0] retire_ar;
  logic [lanes-1:0][prw-1:0] retire_pr;

  int vec [max_lines][field_count];
  int line_count;
  int read_errors;
  int test_errors;
  int pass_count;
  int fail_count;
  bit loaded;

  rename_core rename_core_i (
    .clock        (clock),
    .reset        (reset),
    .rename_valid (rename_valid),
    .dest_ar      (dest_ar),
    .src1_ar      (src1_ar),
    .src2_ar      (src2_ar),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .recover      (recover),
    .stall        (stall),
    .dest_pr      (dest_pr),
    .told         (told),
    .src1_tag     (src1_tag),
    .src2_tag     (src2_tag),
    .src1_ready   (src1_ready),
    .src2_ready   (src2_ready),
    .retire_valid (retire_valid),
    .retire_ar    (retire_ar),
    .retire_pr    (retire_pr)
  );

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  // comment lines start with #, every other line is one cycle
  task automatic load_tests();
    int    fd;
    int    got;
    int    field;
    string token;
    string rest;
    fd = $fopen(test_file, "r");
    if (fd == 0) begin
      $display("error: cannot open test file %s", test_file);
      read_errors++;
      return;
    end
    while (line_count < max_lines) begin
      got = $fscanf(fd, "%s", token);
      if (got != 1) begin
        break;
      end
      if (token.getc(0) == "#") begin
        got = $fgets(rest, fd);
        continue;
      end
      got = $sscanf(token, "%h", vec[line_count][0]);
      field = 1;
      while (got == 1 && field < field_count) begin
        got = $fscanf(fd, "%h", vec[line_count][field]);
        field++;
      end
      if (got != 1) begin
        $display("error: test line %0d of the test file could not be read", line_count + 1);
        read_errors++;
        break;
      end
      line_count++;
    end
    $fclose(fd);
  endtask

  task automatic drive_line(input int i);
    rename_valid <= lanes'(vec[i][1]);
    dest_ar[1]   <= arw'(vec[i][2]);
    dest_ar[0]   <= arw'(vec[i][3]);
    src1_ar[1]   <= arw'(vec[i][4]);
    src1_ar[0]   <= arw'(vec[i][5]);
    src2_ar[1]   <= arw'(vec[i][6]);
    src2_ar[0]   <= arw'(vec[i][7]);
    cdb_valid    <= lanes'(vec[i][8]);
    cdb_tag[1]   <= prw'(vec[i][9]);
    cdb_tag[0]   <= prw'(vec[i][10]);
    recover      <= (vec[i][11] != 0);
  endtask

  task automatic compare(input int i, input string name,
                         input logic [31:0] expected, input logic [31:0] actual);
    if (expected != actual) begin
      $display("[FAIL] test %0d line %0d: %s expected %h got %h",
               vec[i][0], i, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_line(input int i);
    logic [31:0] mask;
    logic [31:0] retire_exp;
    mask       = vec[i][28];
    retire_exp = vec[i][23];
    if (mask[0]) compare(i, "stall", vec[i][12], 32'(stall));
    if (mask[1]) begin
      compare(i, "dest_pr[1]", vec[i][13], 32'(dest_pr[1]));
      compare(i, "dest_pr[0]", vec[i][14], 32'(dest_pr[0]));
    end
    if (mask[2]) begin
      compare(i, "told[1]", vec[i][15], 32'(told[1]));
      compare(i, "told[0]", vec[i][16], 32'(told[0]));
    end
    if (mask[3]) begin
      compare(i, "src1_tag[1]", vec[i][17], 32'(src1_tag[1]));
      compare(i, "src1_tag[0]", vec[i][18], 32'(src1_tag[0]));
      compare(i, "src2_tag[1]", vec[i][19], 32'(src2_tag[1]));
      compare(i, "src2_tag[0]", vec[i][20], 32'(src2_tag[0]));
    end
    if (mask[4]) begin
      compare(i, "src1_ready", vec[i][21], 32'(src1_ready));
      compare(i, "src2_ready", vec[i][22], 32'(src2_ready));
    end
    if (mask[5]) compare(i, "retire_valid", retire_exp, 32'(retire_valid));
    // retire fields only mean something on lanes that should retire
    if (mask[6] && retire_exp[1]) begin
      compare(i, "retire_ar[1]", vec[i][24], 32'(retire_ar[1]));
      compare(i, "retire_pr[1]", vec[i][26], 32'(retire_pr[1]));
    end
    if (mask[6] && retire_exp[0]) begin
      compare(i, "retire_ar[0]", vec[i][25], 32'(retire_ar[0]));
      compare(i, "retire_pr[0]", vec[i][27], 32'(retire_pr[0]));
    end
  endtask

  task automatic report_test(input int id);
    if (test_errors == 0) begin
      $display("test %0d: ok", id);
      pass_count++;
    end else begin
      $display("test %0d: %0d mismatches", id, test_errors);
      fail_count++;
    end
    test_errors = 0;
  endtask

  initial begin
    wait (loaded);
    #(line_count * 2 * half_period * 4 + 1000);
    $display("timeout: the run took longer than its test vectors allow");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    rename_valid = '0;
    dest_ar      = '0;
    src1_ar      = '0;
    src2_ar      = '0;
    cdb_valid    = '0;
    cdb_tag      = '0;
    recover      = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < line_count; i++) begin
      if (i > 0 && vec[i][0] != vec[i-1][0]) begin
        report_test(vec[i-1][0]);
      end
      drive_line(i);
      @(negedge clock);
      check_line(i);
      @(posedge clock);
    end
    if (line_count > 0) begin
      report_test(vec[line_count-1][0]);
    end
    $display("tests ok: %0d, tests with mismatches: %0d, unreadable lines: %0d",
             pass_count, fail_count, read_errors);
    if (fail_count == 0 && read_errors == 0 && line_count > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- verification/rename_tb_sva.sv
// rename checker: concurrent assertions on retirement, allocation and buffer room
module rename_tb_sva (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic                                              recover,
  input  logic [rename_pkg::lanes-1:0]                      retire_valid,
  input  logic [rename_pkg::rmw-1:0]                        room,
  input  logic [rename_pkg::lanes-1:0]                      alloc_en,
  input  logic [rename_pkg::lanes-1:0][rename_pkg::prw-1:0] alloc_tag
);
  import rename_pkg::*;

  // nothing commits while speculative state is thrown away
  no_retire_on_recover: assert property (@(posedge clock) disable iff (reset)
    !(recover && (|retire_valid)))
    else $error("retirement while recover is high");

  // lane 0 takes the second tag whenever lane 1 allocates
  distinct_tags: assert property (@(posedge clock) disable iff (reset)
    (alloc_en[1] && alloc_en[0]) |-> (alloc_tag[1] != alloc_tag[0]))
    else $error("both lanes got the same physical tag");

  room_bounded: assert property (@(posedge clock) disable iff (reset)
    room <= rmw'(rob_depth))
    else $error("reorder buffer room above its depth");

  // a done slot at the head is always one that the buffer holds
  retire_in_range: assert property (@(posedge clock) disable iff (reset)
    (rmw'(retire_valid[1]) + rmw'(retire_valid[0])) <= (rmw'(rob_depth) - room))
    else $error("retired more slots than the buffer holds");

endmodule

bind reorder_buffer rename_tb_sva rob_sva_i (
  .clock        (clock),
  .reset        (reset),
  .recover      (recover),
  .retire_valid (retire_valid),
  .room         (room),
  .alloc_en     (2'b00),
  .alloc_tag    ({2{6'h00}})
);

// release_en is the retire strobe seen from the free list
bind free_list rename_tb_sva free_sva_i (
  .clock        (clock),
  .reset        (reset),
  .recover      (recover),
  .retire_valid (release_en),
  .room         (5'd0),
  .alloc_en     (alloc_en),
  .alloc_tag    (alloc_tag)
);

//--- verification/rename_tests.txt
# test rv d1 d0 s1[1] s1[0] s2[1] s2[0] cdbv cdb1 cdb0 rec | stall pr1 pr0 told1 told0
# s1tag1 s1tag0 s2tag1 s2tag0 s1rdy s2rdy retv rar1 rar0 rpr1 rpr0 | check mask, all hex
# identity after reset, first tags 32 and 33
1 3 01 02 03 04 05 06 0 00 00 0 0 20 21 01 02 03 04 05 06 3 3 0 00 00 00 00 3f
# lane 0 reads lane 1's new tag, same destination patches told
2 3 05 05 01 05 02 00 0 00 00 0 0 22 23 05 22 20 22 21 00 0 1 0 00 00 00 00 3f
# CDB wakeup seen the same cycle, r0 stays ready after rename
3 0 00 00 01 02 00 05 2 20 00 0 0 00 00 00 00 20 21 00 23 2 2 0 00 00 00 00 39
3 2 00 03 01 00 02 01 0 00 00 0 0 24 25 00 03 20 24 21 20 3 1 2 01 00 20 00 7f
3 0 00 00 00 01 05 02 0 00 00 0 0 00 00 00 00 24 20 23 21 3 0 0 00 00 00 00 39
# in-order retirement, blocked behind the head, then told reuse
4 0 00 00 05 00 00 00 3 22 23 0 0 00 00 00 00 23 24 24 24 3 3 0 00 00 00 00 39
4 0 00 00 00 00 00 00 0 00 00 0 0 00 00 00 00 00 00 00 00 0 0 0 00 00 00 00 21
4 0 00 00 00 00 00 00 2 21 00 0 0 00 00 00 00 00 00 00 00 0 0 0 00 00 00 00 21
4 0 00 00 00 00 00 00 0 00 00 0 0 00 00 00 00 00 00 00 00 0 0 3 02 05 21 22 61
4 2 06 07 06 06 00 00 0 00 00 0 0 01 02 06 07 06 01 24 24 2 3 2 05 00 23 00 7f
4 3 08 09 00 00 00 00 0 00 00 0 0 02 05 08 09 00 00 00 00 0 0 0 00 00 00 00 27
# fill the reorder buffer, then stall without consuming tags
5 3 0a 0b 00 00 00 00 0 00 00 0 0 22 25 00 00 00 00 00 00 0 0 0 00 00 00 00 23
5 3 0c 0d 00 00 00 00 0 00 00 0 0 26 27 00 00 00 00 00 00 0 0 0 00 00 00 00 23
5 3 0e 0f 00 00 00 00 0 00 00 0 0 28 29 00 00 00 00 00 00 0 0 0 00 00 00 00 23
5 3 10 11 00 00 00 00 0 00 00 0 0 2a 2b 00 00 00 00 00 00 0 0 0 00 00 00 00 23
5 3 12 13 00 00 00 00 0 00 00 0 0 2c 2d 00 00 00 00 00 00 0 0 0 00 00 00 00 23
5 3 14 15 00 00 00 00 0 00 00 0 0 2e 2f 00 00 00 00 00 00 0 0 0 00 00 00 00 23
5 3 16 17 00 00 00 00 0 00 00 0 1 30 31 00 00 00 00 00 00 0 0 0 00 00 00 00 23
5 3 16 17 00 00 00 00 0 00 00 0 1 30 31 00 00 00 00 00 00 0 0 0 00 00 00 00 23
5 0 00 00 00 00 00 00 0 00 00 0 0 00 00 00 00 00 00 00 00 0 0 0 00 00 00 00 21
# recovery restores the committed map and rebuilds the free list
6 3 16 17 00 00 00 00 0 00 00 1 0 00 00 00 00 00 00 00 00 0 0 0 00 00 00 00 20
6 3 03 04 01 05 02 06 0 00 00 0 0 01 02 03 04 20 23 21 06 3 3 0 00 00 00 00 3f

//--- verilog.f
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/map_table.sv
hdl/reorder_buffer.sv
hdl/arch_map_table.sv
hdl/rename_core.sv
verification/rename_tb_sva.sv
verification/rename_tb.sv
